// File: tb.f
+incdir+.
histoPkg.sv
histoRam.sv
binAccumulator.sv
peakFinder.sv
ramArbiter.sv
histoTop.sv
clkGen.sv
tbHisto.sv

// File: tbHisto.sv
`timescale 1ns/1ps
`default_nettype none

`include "histo_defs.svh"

module tbHisto;

    import histoPkg::*;

    localparam int modeFixed   = 0;
    localparam int modeRandom  = 1;
    localparam int modeAlt     = 2;    // binA and binB in turn
    localparam int rowNum      = 9;
    localparam int waitLimit   = 200;  // cycles per wait
    localparam int countLimit  = (1 << `COUNT_W) - 1;

    typedef struct packed {
        int count;     // samples back to back
        int mode;
        int binA;
        int binB;
        bit scan;      // scan right after the last sample
        bit handExp;   // the three columns below are valid
        int expBin;
        int expCount;
        int expTotal;
    } rowT;

    logic    clk;
    logic    res;
    logic    sampleValid;
    sampleT  sampleData;
    logic    scanStart;
    logic    scanBusy;
    logic    scanDone;
    binAddrT peakBin;
    countT   peakCount;
    totalT   totalCount;

    rowT         stimRows [rowNum];
    int          refBins [`BIN_NUM];  // reference histogram
    logic [31:0] rngState;

    clkGen u_clkGen (
        .clk (clk),
        .res (res)
    );

    histoTop u_histoTop (
        .clk         (clk),
        .res         (res),
        .sampleValid (sampleValid),
        .sampleData  (sampleData),
        .scanStart   (scanStart),
        .scanBusy    (scanBusy),
        .scanDone    (scanDone),
        .peakBin     (peakBin),
        .peakCount   (peakCount),
        .totalCount  (totalCount)
    );

    function automatic logic [31:0] nextRandom(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic stopOnFailure(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stopOnFailure($sformatf("[FAIL] %0t %s got %0b expected %0b",
                                    $time, name, got, exp));
        end
    endtask

    task automatic checkBin(input string name, input binAddrT got, input binAddrT exp);
        if (got !== exp) begin
            stopOnFailure($sformatf("[FAIL] %0t %s got %0d expected %0d",
                                    $time, name, got, exp));
        end
    endtask

    task automatic checkCount(input string name, input countT got, input countT exp);
        if (got !== exp) begin
            stopOnFailure($sformatf("[FAIL] %0t %s got %0d expected %0d",
                                    $time, name, got, exp));
        end
    endtask

    task automatic checkTotal(input string name, input totalT got, input totalT exp);
        if (got !== exp) begin
            stopOnFailure($sformatf("[FAIL] %0t %s got %0d expected %0d",
                                    $time, name, got, exp));
        end
    endtask

    task automatic modelAdd(input binAddrT bin);
        if (refBins[bin] < countLimit) begin
            refBins[bin] = refBins[bin] + 1;
        end
    endtask

    task automatic modelScan(output binAddrT bin, output countT cnt, output totalT sum);
        int best;
        int total;
        best  = 0;
        total = 0;
        bin   = '0;
        for (int i = 0; i < `BIN_NUM; i++) begin
            total = total + refBins[i];
            if (refBins[i] > best) begin  // first of equal counts stays
                best = refBins[i];
                bin  = binAddrT'(i);
            end
            refBins[i] = 0;
        end
        cnt = countT'(best);
        sum = totalT'(total);
    endtask

    task automatic waitForReset();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (res !== 1'b1) begin
            if (cycles == waitLimit) begin
                stopOnFailure("reset was never released");
            end
            cycles++;
            @(negedge clk);
        end
    endtask

    task automatic waitScanDone();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (scanDone !== 1'b1) begin
            if (cycles == waitLimit) begin
                stopOnFailure("scan hung, scanDone never came");
            end
            checkFlag("scanBusy", scanBusy, 1'b1);  // busy for the whole walk
            cycles++;
            @(negedge clk);
        end
        checkFlag("scanBusy", scanBusy, 1'b0);
    endtask

    task automatic applyRow(input rowT row);
        sampleT  data;
        binAddrT expBin;
        countT   expCount;
        totalT   expTotal;
        for (int n = 0; n < row.count; n++) begin
            if (row.mode == modeRandom) begin
                rngState = nextRandom(rngState);
                data     = rngState[`SAMPLE_W-1:0];
            end else if (row.mode == modeAlt && (n % 2) == 1) begin
                data = sampleT'((n << `BIN_ADDR_W) | row.binB);  // junk in high bits
            end else begin
                data = sampleT'((n << `BIN_ADDR_W) | row.binA);
            end
            @(posedge clk);
            sampleValid <= 1'b1;
            sampleData  <= data;
            modelAdd(data[`BIN_ADDR_W-1:0]);
        end
        @(posedge clk);
        sampleValid <= 1'b0;
        if (row.scan) begin
            scanStart <= 1'b1;  // one cycle after the last sample
            @(posedge clk);
            scanStart <= 1'b0;
            waitScanDone();
            modelScan(expBin, expCount, expTotal);
            checkBin("peakBin", peakBin, expBin);
            checkCount("peakCount", peakCount, expCount);
            checkTotal("totalCount", totalCount, expTotal);
            if (row.handExp) begin
                checkBin("peakBin", peakBin, binAddrT'(row.expBin));
                checkCount("peakCount", peakCount, countT'(row.expCount));
                checkTotal("totalCount", totalCount, totalT'(row.expTotal));
            end
        end
    endtask

    initial begin
        sampleValid = 1'b0;
        sampleData  = '0;
        scanStart   = 1'b0;
        rngState    = 32'ha560;
        for (int i = 0; i < `BIN_NUM; i++) begin
            refBins[i] = 0;
        end
        stimRows[0] = '{40, modeRandom, 0, 0, 1'b1, 1'b0, 0, 0, 0};
        stimRows[1] = '{30, modeFixed, 5, 0, 1'b1, 1'b1, 5, 30, 30};      // forwarding
        stimRows[2] = '{300, modeFixed, 3, 0, 1'b0, 1'b0, 0, 0, 0};
        stimRows[3] = '{10, modeAlt, 7, 8, 1'b1, 1'b1, 3, 255, 265};      // saturated
        stimRows[4] = '{1, modeFixed, 0, 0, 1'b1, 1'b1, 0, 1, 1};         // bin 0 read first
        stimRows[5] = '{0, modeFixed, 0, 0, 1'b1, 1'b1, 0, 0, 0};         // bins cleared
        stimRows[6] = '{8, modeAlt, 12, 6, 1'b1, 1'b1, 6, 4, 8};          // tie
        stimRows[7] = '{5, modeFixed, 14, 0, 1'b0, 1'b0, 0, 0, 0};
        stimRows[8] = '{5, modeFixed, 2, 0, 1'b1, 1'b1, 2, 5, 10};
        waitForReset();
        checkFlag("scanBusy", scanBusy, 1'b0);
        checkFlag("scanDone", scanDone, 1'b0);
        checkBin("peakBin", peakBin, '0);
        checkCount("peakCount", peakCount, '0);
        checkTotal("totalCount", totalCount, '0);
        for (int r = 0; r < rowNum; r++) begin
            applyRow(stimRows[r]);
        end
        @(posedge clk);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: clkGen.sv
`timescale 1ns/1ps
`default_nettype none

module clkGen (
    output logic clk,
    output logic res
);

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;  // 10 ns period
        end
    end

    initial begin
        res = 1'b0;
        repeat (2) @(posedge clk);
        res <= 1'b1;  // released after two edges
    end

endmodule

`default_nettype wire

// File: histoTop.sv
`timescale 1ns/1ps
`default_nettype none

module histoTop (
    input  wire                    clk,
    input  wire                    res,
    input  wire                    sampleValid,
    input  wire histoPkg::sampleT  sampleData,
    input  wire                    scanStart,
    output logic                   scanBusy,
    output logic                   scanDone,
    output histoPkg::binAddrT      peakBin,
    output histoPkg::countT        peakCount,
    output histoPkg::totalT        totalCount
);

    import histoPkg::*;

    // accumulator side
    logic    accRdEn;
    binAddrT accRdAddr;
    logic    accWrEn;
    binAddrT accWrAddr;
    countT   accWrData;

    // finder side
    logic    finRdEn;
    binAddrT finRdAddr;
    logic    finWrEn;
    binAddrT finWrAddr;
    countT   finWrData;
    logic    finGrant;

    // shared RAM ports
    logic    ramRdEn;
    binAddrT ramRdAddr;
    logic    ramWrEn;
    binAddrT ramWrAddr;
    countT   ramWrData;
    countT   ramRdData;  // read data fans out to both masters

    histoRam u_histoRam (
        .clk    (clk),
        .res    (res),
        .wrEn   (ramWrEn),
        .wrAddr (ramWrAddr),
        .wrData (ramWrData),
        .rdEn   (ramRdEn),
        .rdAddr (ramRdAddr),
        .rdData (ramRdData)
    );

    binAccumulator u_binAccumulator (
        .clk         (clk),
        .res         (res),
        .sampleValid (sampleValid),
        .sampleData  (sampleData),
        .rdEn        (accRdEn),
        .rdAddr      (accRdAddr),
        .rdData      (ramRdData),
        .wrEn        (accWrEn),
        .wrAddr      (accWrAddr),
        .wrData      (accWrData)
    );

    peakFinder u_peakFinder (
        .clk        (clk),
        .res        (res),
        .scanStart  (scanStart),
        .grant      (finGrant),
        .rdEn       (finRdEn),
        .rdAddr     (finRdAddr),
        .rdData     (ramRdData),
        .wrEn       (finWrEn),
        .wrAddr     (finWrAddr),
        .wrData     (finWrData),
        .scanBusy   (scanBusy),
        .scanDone   (scanDone),
        .peakBin    (peakBin),
        .peakCount  (peakCount),
        .totalCount (totalCount)
    );

    ramArbiter u_ramArbiter (
        .clk       (clk),
        .res       (res),
        .accRdEn   (accRdEn),
        .accRdAddr (accRdAddr),
        .accWrEn   (accWrEn),
        .accWrAddr (accWrAddr),
        .accWrData (accWrData),
        .finRdEn   (finRdEn),
        .finRdAddr (finRdAddr),
        .finWrEn   (finWrEn),
        .finWrAddr (finWrAddr),
        .finWrData (finWrData),
        .finGrant  (finGrant),
        .ramRdEn   (ramRdEn),
        .ramRdAddr (ramRdAddr),
        .ramWrEn   (ramWrEn),
        .ramWrAddr (ramWrAddr),
        .ramWrData (ramWrData)
    );

endmodule

`default_nettype wire

// File: ramArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module ramArbiter (
    input  wire                    clk,
    input  wire                    res,
    input  wire                    accRdEn,
    input  wire histoPkg::binAddrT accRdAddr,
    input  wire                    accWrEn,
    input  wire histoPkg::binAddrT accWrAddr,
    input  wire histoPkg::countT   accWrData,
    input  wire                    finRdEn,
    input  wire histoPkg::binAddrT finRdAddr,
    input  wire                    finWrEn,
    input  wire histoPkg::binAddrT finWrAddr,
    input  wire histoPkg::countT   finWrData,
    output logic                   finGrant,
    output logic                   ramRdEn,
    output histoPkg::binAddrT      ramRdAddr,
    output logic                   ramWrEn,
    output histoPkg::binAddrT      ramWrAddr,
    output histoPkg::countT        ramWrData
);

    logic [1:0] accTrail;  // accumulator stages behind its read

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            accTrail <= '0;
        end else begin
            accTrail <= {accTrail[0], accRdEn};
        end
    end

    // accumulator cannot stall, finder only gets a quiet pipeline
    assign finGrant = !(accRdEn || accWrEn || (|accTrail));

    always_comb begin
        if (finGrant) begin
            ramRdEn   = finRdEn;
            ramRdAddr = finRdAddr;
            ramWrEn   = finWrEn;
            ramWrAddr = finWrAddr;
            ramWrData = finWrData;
        end else begin
            ramRdEn   = accRdEn;
            ramRdAddr = accRdAddr;
            ramWrEn   = accWrEn;
            ramWrAddr = accWrAddr;
            ramWrData = accWrData;
        end
    end

endmodule

`default_nettype wire

// File: peakFinder.sv
`timescale 1ns/1ps
`default_nettype none

`include "histo_defs.svh"

module peakFinder (
    input  wire                    clk,
    input  wire                    res,
    input  wire                    scanStart,
    input  wire                    grant,
    output logic                   rdEn,
    output histoPkg::binAddrT      rdAddr,
    input  wire histoPkg::countT   rdData,
    output logic                   wrEn,
    output histoPkg::binAddrT      wrAddr,
    output histoPkg::countT        wrData,
    output logic                   scanBusy,
    output logic                   scanDone,
    output histoPkg::binAddrT      peakBin,
    output histoPkg::countT        peakCount,
    output histoPkg::totalT        totalCount
);

    import histoPkg::*;

    localparam binAddrT lastBin = binAddrT'(`BIN_NUM - 1);

    scanStateT state;
    binAddrT   binIdx;
    binAddrT   maxBin;     // running peak location
    countT     maxCount;
    totalT     runTotal;
    logic      dataFresh;  // rdData answers our granted read
    countT     heldCount;
    countT     curCount;

    assign rdEn     = (state == scanRead);
    assign rdAddr   = binIdx;
    assign wrEn     = (state == scanWait);
    assign wrAddr   = binIdx;
    assign wrData   = '0;  // bin cleared after it is read
    assign curCount = dataFresh ? rdData : heldCount;

    // rdData is only valid for one cycle, keep it while the write waits
    always_ff @(posedge clk) begin
        heldCount <= curCount;
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state      <= scanIdle;
            binIdx     <= '0;
            maxBin     <= '0;
            maxCount   <= '0;
            runTotal   <= '0;
            dataFresh  <= 1'b0;
            scanBusy   <= 1'b0;
            scanDone   <= 1'b0;
            peakBin    <= '0;
            peakCount  <= '0;
            totalCount <= '0;
        end else begin
            scanDone  <= 1'b0;
            dataFresh <= 1'b0;
            case (state)
                scanIdle: begin
                    if (scanStart) begin
                        binIdx   <= '0;
                        maxBin   <= '0;
                        maxCount <= '0;
                        runTotal <= '0;
                        scanBusy <= 1'b1;
                        state    <= scanRead;
                    end
                end
                scanRead: begin
                    if (grant) begin
                        dataFresh <= 1'b1;  // RAM answers next cycle
                        state     <= scanWait;
                    end
                end
                scanWait: begin
                    if (grant) begin
                        if (curCount > maxCount) begin  // strict, lower bin keeps a tie
                            maxCount <= curCount;
                            maxBin   <= binIdx;
                        end
                        runTotal <= runTotal + totalT'(curCount);
                        if (binIdx == lastBin) begin
                            state <= scanReport;
                        end else begin
                            binIdx <= binIdx + 1'b1;
                            state  <= scanRead;
                        end
                    end
                end
                scanReport: begin
                    peakBin    <= maxBin;
                    peakCount  <= maxCount;
                    totalCount <= runTotal;
                    scanDone   <= 1'b1;
                    scanBusy   <= 1'b0;
                    state      <= scanIdle;
                end
                default: begin
                    state <= scanIdle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: binAccumulator.sv
`timescale 1ns/1ps
`default_nettype none

`include "histo_defs.svh"

module binAccumulator (
    input  wire                    clk,
    input  wire                    res,
    input  wire                    sampleValid,
    input  wire histoPkg::sampleT  sampleData,
    output logic                   rdEn,
    output histoPkg::binAddrT      rdAddr,
    input  wire histoPkg::countT   rdData,
    output logic                   wrEn,
    output histoPkg::binAddrT      wrAddr,
    output histoPkg::countT        wrData
);

    import histoPkg::*;

    localparam countT countMax = '1;

    logic    s1Valid;   // read issued
    logic    s2Valid;   // RAM data arriving
    logic    s3Valid;   // write issued
    logic    s4Valid;   // write landed last cycle
    binAddrT s1Addr;
    binAddrT s2Addr;
    binAddrT s3Addr;
    binAddrT s4Addr;
    countT   s3Count;
    countT   s4Count;
    countT   baseCount;
    countT   nextCount;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1Valid <= 1'b0;
            s2Valid <= 1'b0;
            s3Valid <= 1'b0;
            s4Valid <= 1'b0;
        end else begin
            s1Valid <= sampleValid;
            s2Valid <= s1Valid;
            s3Valid <= s2Valid;
            s4Valid <= s3Valid;
        end
    end

    always_ff @(posedge clk) begin
        s1Addr  <= sampleData[`BIN_ADDR_W-1:0];  // bin from low bits
        s2Addr  <= s1Addr;
        s3Addr  <= s2Addr;
        s3Count <= nextCount;
        s4Addr  <= s3Addr;
        s4Count <= s3Count;
    end

    // The RAM read for stage 2 went out one cycle ago. It misses the write
    // in progress now (stage 3) and the one that shared its read cycle
    // (stage 4), so those are forwarded, newest first.
    always_comb begin
        if (s3Valid && (s3Addr == s2Addr)) begin
            baseCount = s3Count;
        end else if (s4Valid && (s4Addr == s2Addr)) begin
            baseCount = s4Count;
        end else begin
            baseCount = rdData;
        end
        if (baseCount == countMax) begin
            nextCount = baseCount;  // saturate
        end else begin
            nextCount = baseCount + 1'b1;
        end
    end

    assign rdEn   = s1Valid;
    assign rdAddr = s1Addr;
    assign wrEn   = s3Valid;
    assign wrAddr = s3Addr;
    assign wrData = s3Count;

endmodule

`default_nettype wire

// File: histoRam.sv
`timescale 1ns/1ps
`default_nettype none

`include "histo_defs.svh"

module histoRam (
    input  wire                    clk,
    input  wire                    res,
    input  wire                    wrEn,
    input  wire histoPkg::binAddrT wrAddr,
    input  wire histoPkg::countT   wrData,
    input  wire                    rdEn,
    input  wire histoPkg::binAddrT rdAddr,
    output histoPkg::countT        rdData
);

    import histoPkg::*;

    countT mem [`BIN_NUM];

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            rdData <= '0;
            for (int i = 0; i < `BIN_NUM; i++) begin
                mem[i] <= '0;  // frame starts empty
            end
        end else begin
            if (rdEn) begin
                rdData <= mem[rdAddr];  // old data on same-cycle write
            end
            if (wrEn) begin
                mem[wrAddr] <= wrData;
            end
        end
    end

endmodule

`default_nettype wire

// File: histoPkg.sv
`default_nettype none

`include "histo_defs.svh"

package histoPkg;

    typedef logic [`SAMPLE_W-1:0]   sampleT;   // raw sample word
    typedef logic [`BIN_ADDR_W-1:0] binAddrT;  // bin index and RAM address
    typedef logic [`COUNT_W-1:0]    countT;    // one bin's count
    typedef logic [`TOTAL_W-1:0]    totalT;    // histogram total

    // peak finder states
    typedef enum logic [1:0] {
        scanIdle,    // waiting for scanStart
        scanRead,    // read request held until granted
        scanWait,    // data back, compare and clear the bin
        scanReport   // latch results, pulse scanDone
    } scanStateT;

endpackage

`default_nettype wire

// File: histo_defs.svh
`ifndef HISTO_DEFS_SVH
`define HISTO_DEFS_SVH

`define SAMPLE_W   12  // photon sample word
`define BIN_ADDR_W 4   // bin index, taken from low sample bits
`define BIN_NUM    16  // one RAM word per bin
`define COUNT_W    8   // per-bin counter, saturating
`define TOTAL_W    12  // sum of all bins, never wraps

`endif
